//--- frontend_defs.svh
/* global widths and limits for the fetch front end
   FE_MAX_INFLIGHT sets the pc queue depth and should stay a power of two */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset release
`define FE_RESET_PC 32'h8000_0000

// outstanding AXI reads allowed at once
`define FE_MAX_INFLIGHT 4

`endif

//--- axi_pkg.sv
/* AXI4-lite read channel payloads, handshake signals travel separately
   rresp is carried but not interpreted by the front end */
`include "frontend_defs.svh"

package axi_pkg;

  // unprivileged, secure, data access
  localparam logic [2:0] AXI_PROT_DEFAULT = 3'b000;

  // read address channel payload
  typedef struct packed {
    logic [`XLEN-1:0] araddr;
    logic [2:0]       arprot;
  } axi_ar_t;

  // read data channel payload
  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic [1:0]       rresp;
  } axi_r_t;

endpackage

//--- rv_pkg.sv
/* RV32I encoding views and the decoded fetch packet
   only the base 32-bit encoding is covered, compressed forms are not */
`include "frontend_defs.svh"

package rv_pkg;

  // major opcodes used by the decoder
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_ILL
  } rv_fmt_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_t;

  // branch offset is scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_t;

  // one instruction word, read through whichever format applies
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_b_t b;
    rv_u_t u;
    rv_j_t j;
  } rv_inst_u;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
    rv_fmt_e          fmt;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic             uses_rd;
    logic             uses_rs1;
    logic             uses_rs2;
  } fetch_pkt_t;

endpackage

//--- fetch_ctrl.sv
/* issues one AXI read per accepted next-pc, boot fetch from FE_RESET_PC
   caller must not push into a full pc queue, ar_valid is held off instead */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module fetch_ctrl (
  input  logic               clk,
  input  logic               rstn,
  input  logic               npc_valid,
  input  logic [`XLEN-1:0]   npc,
  output logic               npc_ready,
  output logic               ar_valid,
  input  logic               ar_ready,
  output axi_pkg::axi_ar_t   ar,
  input  logic               q_full,
  output logic               q_push,
  output logic [`XLEN-1:0]   q_pc
);
  import axi_pkg::*;

  typedef enum logic [1:0] {
    ST_RESET,
    ST_BOOT,
    ST_RUN
  } state_e;

  state_e             state;
  logic               pend_valid;
  logic [`XLEN-1:0]   pend_addr;
  logic               npc_fire;
  logic               ar_fire;

  // a new npc is only taken in run phase with the slot free
  assign npc_ready = (state == ST_RUN) && !pend_valid;
  assign npc_fire  = npc_valid && npc_ready;

  // in-flight limit enforced here through the queue full flag
  assign ar_valid = pend_valid && !q_full;
  assign ar_fire  = ar_valid && ar_ready;

  assign ar.araddr = pend_addr;
  assign ar.arprot = AXI_PROT_DEFAULT;

  // every issued address is remembered until its data returns
  assign q_push = ar_fire;
  assign q_pc   = pend_addr;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_RESET;
    end else begin
      case (state)
        ST_RESET: state <= ST_BOOT;
        ST_BOOT:  state <= ST_RUN;
        default:  state <= ST_RUN;
      endcase
    end
  end

  // pending slot valid flag
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pend_valid <= 1'b0;
    end else if (state == ST_BOOT) begin
      pend_valid <= 1'b1;
    end else if (npc_fire) begin
      pend_valid <= 1'b1;
    end else if (ar_fire) begin
      pend_valid <= 1'b0;
    end
  end

  // pending address payload
  always_ff @(posedge clk) begin
    if (state == ST_BOOT) begin
      pend_addr <= `FE_RESET_PC;
    end else if (npc_fire) begin
      pend_addr <= npc;
    end
  end

endmodule

//--- pc_queue.sv
/* circular FIFO of issued pcs, one entry per outstanding read
   no empty flag, pop is only legal while a read is outstanding */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module pc_queue (
  input  logic               clk,
  input  logic               rstn,
  input  logic               push,
  input  logic [`XLEN-1:0]   push_pc,
  input  logic               pop,
  output logic               full,
  output logic [`XLEN-1:0]   head_pc
);
  localparam int DEPTH = `FE_MAX_INFLIGHT;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`XLEN-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full    = (count == CNT_W'(DEPTH));
  assign head_pc = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves occupancy unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- inst_decoder.sv
/* purely combinational RV32I field and immediate extraction
   unknown opcodes give FMT_ILL with zero immediate, funct fields are not checked */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module inst_decoder (
  input  logic [`XLEN-1:0] word,
  input  logic [`XLEN-1:0] pc,
  output rv_pkg::fetch_pkt_t pkt
);
  import rv_pkg::*;

  rv_inst_u inst;
  rv_fmt_e  fmt;

  assign inst = word;

  always_comb begin
    case (inst.r.opcode)
      OPC_LUI, OPC_AUIPC: fmt = FMT_U;
      OPC_JAL:            fmt = FMT_J;
      OPC_JALR, OPC_LOAD, OPC_OPIMM, OPC_SYSTEM: begin
        fmt = FMT_I;
      end
      OPC_BRANCH:         fmt = FMT_B;
      OPC_STORE:          fmt = FMT_S;
      OPC_OP:             fmt = FMT_R;
      default:            fmt = FMT_ILL;
    endcase
  end

  always_comb begin
    pkt.pc   = pc;
    pkt.inst = word;
    pkt.fmt  = fmt;
    // register fields are passed through raw regardless of format
    pkt.rd   = inst.r.rd;
    pkt.rs1  = inst.r.rs1;
    pkt.rs2  = inst.r.rs2;

    case (fmt)
      FMT_I: pkt.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
      FMT_S: pkt.imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      FMT_B: begin
        pkt.imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                   inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      end
      FMT_U: pkt.imm = {inst.u.imm_31_12, 12'b0};
      FMT_J: begin
        pkt.imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                   inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      end
      default: pkt.imm = '0;
    endcase

    // operand usage, ILL claims nothing
    case (fmt)
      FMT_R:        {pkt.uses_rd, pkt.uses_rs1, pkt.uses_rs2} = 3'b111;
      FMT_I:        {pkt.uses_rd, pkt.uses_rs1, pkt.uses_rs2} = 3'b110;
      FMT_S, FMT_B: {pkt.uses_rd, pkt.uses_rs1, pkt.uses_rs2} = 3'b011;
      FMT_U, FMT_J: {pkt.uses_rd, pkt.uses_rs1, pkt.uses_rs2} = 3'b100;
      default:      {pkt.uses_rd, pkt.uses_rs1, pkt.uses_rs2} = 3'b000;
    endcase
  end

endmodule

//--- inst_buffer.sv
/* two-entry packet FIFO between the AXI R channel and the consumer
   r_ready is low in reset and when both entries hold a packet */
`timescale 1ns/1ps

module inst_buffer (
  input  logic               clk,
  input  logic               rstn,
  input  logic               r_valid,
  output logic               r_ready,
  input  rv_pkg::fetch_pkt_t in_pkt,
  output logic               out_valid,
  input  logic               out_ready,
  output rv_pkg::fetch_pkt_t out,
  output logic               pop
);
  import rv_pkg::*;

  // head drives the output directly and skid catches one more
  fetch_pkt_t head_q;
  fetch_pkt_t skid_q;
  logic       head_v;
  logic       skid_v;
  logic       push;
  logic       deq;

  assign r_ready   = rstn && !(head_v && skid_v);
  assign push      = r_valid && r_ready;
  assign deq       = head_v && out_ready;
  assign pop       = push;
  assign out_valid = head_v;
  assign out       = head_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      head_v <= 1'b0;
      skid_v <= 1'b0;
    end else if (deq) begin
      // a full buffer blocks push so skid and push never meet here
      if (skid_v) begin
        skid_v <= 1'b0;
      end else begin
        head_v <= push;
      end
    end else if (push) begin
      if (head_v) begin
        skid_v <= 1'b1;
      end else begin
        head_v <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deq && skid_v) begin
      head_q <= skid_q;
    end else if (push && (!head_v || deq)) begin
      head_q <= in_pkt;
    end else if (push) begin
      skid_q <= in_pkt;
    end
  end

endmodule

//--- fetch_frontend.sv
/* RV32I fetch front end, npc in, AXI4-lite read out, decoded packets out
   packets leave in issue order, rresp errors are not reported */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module fetch_frontend (
  input  logic               clk,
  input  logic               rstn,
  input  logic               npc_valid,
  output logic               npc_ready,
  input  logic [`XLEN-1:0]   npc,
  output logic               ar_valid,
  input  logic               ar_ready,
  output axi_pkg::axi_ar_t   ar,
  input  logic               r_valid,
  output logic               r_ready,
  input  axi_pkg::axi_r_t    r,
  output logic               out_valid,
  input  logic               out_ready,
  output rv_pkg::fetch_pkt_t out
);
  import rv_pkg::*;

  logic             q_push;
  logic [`XLEN-1:0] q_pc;
  logic             q_full;
  logic             q_pop;
  logic [`XLEN-1:0] head_pc;
  fetch_pkt_t       dec_pkt;

  fetch_ctrl u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .npc_valid (npc_valid),
    .npc       (npc),
    .npc_ready (npc_ready),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .q_full    (q_full),
    .q_push    (q_push),
    .q_pc      (q_pc)
  );

  pc_queue u_pcq (
    .clk     (clk),
    .rstn    (rstn),
    .push    (q_push),
    .push_pc (q_pc),
    .pop     (q_pop),
    .full    (q_full),
    .head_pc (head_pc)
  );

  // returned word pairs with the oldest outstanding pc
  inst_decoder u_dec (
    .word (r.rdata),
    .pc   (head_pc),
    .pkt  (dec_pkt)
  );

  inst_buffer u_buf (
    .clk       (clk),
    .rstn      (rstn),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .in_pkt    (dec_pkt),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out),
    .pop       (q_pop)
  );

endmodule

//--- tb_fetch_frontend.sv
/* AXI memory model answers reads in order after 0 to 5 idle cycles
   run from the project root so tb_fetch_input.txt is found */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module tb_fetch_frontend;
  import axi_pkg::*;
  import rv_pkg::*;

  localparam int NUM_REC = 16;
  localparam int REC_W   = 8;
  localparam int TIMEOUT = 2000;

  logic             clk       = 1'b0;
  logic             rstn      = 1'b0;
  logic             npc_valid = 1'b0;
  logic [`XLEN-1:0] npc       = '0;
  logic             ar_ready  = 1'b1;
  logic             r_valid   = 1'b0;
  axi_r_t           r         = '0;
  logic             out_ready = 1'b0;
  logic             npc_ready;
  logic             ar_valid;
  axi_ar_t          ar;
  logic             r_ready;
  logic             out_valid;
  fetch_pkt_t       out;

  // eight words per record as laid out in the input file
  logic [31:0] rec [NUM_REC*REC_W];
  logic [31:0] imem [logic [31:0]];
  logic [31:0] rd_q [$];
  int          exp_q [$];
  integer      seed;
  int          errors;
  int          ar_cnt;
  int          r_cnt;
  int          pkt_cnt;
  int          npc_idx;
  int          wait_cnt;
  int          phase_cnt;
  int          cycles;
  int          idx;
  logic        npc_fire;
  logic        ar_fire;
  logic        r_fire;
  logic        out_fire;

  fetch_frontend dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .npc_valid (npc_valid),
    .npc_ready (npc_ready),
    .npc       (npc),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r         (r),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
  );

  always #2 clk = ~clk;

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic score_packet();
    int b;
    if (exp_q.size() == 0) begin
      errors++;
      $display("packet with pc %h arrived with no fetch outstanding", out.pc);
    end else begin
      b = exp_q.pop_front() * REC_W;
      // boot fetch comes first
      if (b == 0) begin
        check_equal("out.pc", out.pc, `FE_RESET_PC);
      end
      check_equal("out.pc", out.pc, rec[b]);
      check_equal("out.inst", out.inst, rec[b+1]);
      check_equal("out.fmt", 32'(out.fmt), rec[b+2]);
      check_equal("out.rd", 32'(out.rd), rec[b+3]);
      check_equal("out.rs1", 32'(out.rs1), rec[b+4]);
      check_equal("out.rs2", 32'(out.rs2), rec[b+5]);
      check_equal("out.imm", out.imm, rec[b+6]);
      check_equal("out.uses", 32'({out.uses_rd, out.uses_rs1, out.uses_rs2}), rec[b+7]);
      pkt_cnt++;
    end
  endtask

  // sample between edges where inputs are stable
  always @(negedge clk) begin
    npc_fire = npc_valid && npc_ready;
    ar_fire  = ar_valid && ar_ready;
    r_fire   = r_valid && r_ready;
    out_fire = out_valid && out_ready;
    if (!rstn) begin
      check_equal("npc_ready", 32'(npc_ready), 32'd0);
      check_equal("ar_valid", 32'(ar_valid), 32'd0);
      check_equal("r_ready", 32'(r_ready), 32'd0);
      check_equal("out_valid", 32'(out_valid), 32'd0);
    end
    if (npc_fire) begin
      exp_q.push_back(npc_idx);
    end
    if (ar_fire) begin
      rd_q.push_back(ar.araddr);
      check_equal("ar.arprot", 32'(ar.arprot), 32'd0);
      ar_cnt++;
    end
    if (r_fire) begin
      void'(rd_q.pop_front());
      r_cnt++;
    end
    if (ar_cnt - r_cnt > `FE_MAX_INFLIGHT) begin
      errors++;
      $display("more than %0d reads outstanding at %0t", `FE_MAX_INFLIGHT, $time);
    end
    if (out_fire) begin
      score_packet();
    end
  end

  // execute stage, memory model and consumer
  always @(posedge clk) begin
    #1;
    if (npc_fire) begin
      npc_idx++;
    end
    npc_valid = (npc_idx < NUM_REC);
    npc = (npc_idx < NUM_REC) ? rec[npc_idx*REC_W] : '0;
    if (r_fire) begin
      r_valid  = 1'b0;
      wait_cnt = $unsigned($random(seed)) % 6;
    end
    if (!r_valid && rd_q.size() > 0) begin
      if (wait_cnt == 0) begin
        r_valid = 1'b1;
        r.rdata = imem[rd_q[0]];
      end else begin
        wait_cnt--;
      end
    end
    // out_ready holds each level for a random run of cycles
    if (phase_cnt == 0) begin
      out_ready = ($unsigned($random(seed)) % 3) != 0;
      phase_cnt = $unsigned($random(seed)) % 8;
    end else begin
      phase_cnt--;
    end
  end

  initial begin
    seed      = 32'h475c_8aca;
    errors    = 0;
    ar_cnt    = 0;
    r_cnt     = 0;
    pkt_cnt   = 0;
    npc_idx   = 1;
    wait_cnt  = 0;
    phase_cnt = 0;
    npc_fire  = 1'b0;
    ar_fire   = 1'b0;
    r_fire    = 1'b0;
    out_fire  = 1'b0;
    $readmemh("tb_fetch_input.txt", rec);
    for (idx = 0; idx < NUM_REC; idx++) begin
      imem[rec[idx*REC_W]] = rec[idx*REC_W+1];
    end
    check_equal("rec0 address", rec[0], `FE_RESET_PC);
    // record 0 is fetched by the boot sequence
    exp_q.push_back(0);
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;

    cycles = 0;
    while (pkt_cnt < NUM_REC && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (pkt_cnt < NUM_REC) begin
      errors++;
      $display("timeout after %0d cycles, %0d of %0d packets received",
               cycles, pkt_cnt, NUM_REC);
    end
    // idle tail to catch duplicated packets
    repeat (20) @(posedge clk);
    $display("errors %0d, packets %0d of %0d, reads %0d", errors, pkt_cnt, NUM_REC, ar_cnt);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb_fetch_input.txt
// addr word fmt rd rs1 rs2 imm uses, uses is {rd,rs1,rs2} as one hex digit
// fmt 0 R, 1 I, 2 S, 3 B, 4 U, 5 J, 6 illegal
80000000 00500093 1 01 00 05 00000005 6
80000004 002081b3 0 03 01 02 00000000 7
80000008 fe312e23 2 1c 02 03 fffffffc 3
80000010 00208863 3 10 01 02 00000010 3
80000014 fe629ce3 3 19 05 06 fffffff8 3
80000100 123452b7 4 05 08 03 12345000 4
80000104 fffff397 4 07 1f 1f fffff000 4
80000108 001000ef 5 01 00 01 00000800 4
80001000 ffdff06f 5 00 1f 1d fffffffc 4
80000200 00008067 1 00 01 00 00000000 6
80000204 fff5a503 1 0a 0b 1f ffffffff 6
8000020c 00000073 1 00 00 00 00000000 6
80000210 ffffffff 6 1f 1f 1f 00000000 0
80000ffc 40628233 0 04 05 06 00000000 7
80000400 0000000b 6 00 00 00 00000000 0
80000404 4030d093 1 01 01 03 00000403 6

//--- src.f
+incdir+.
axi_pkg.sv
rv_pkg.sv
fetch_ctrl.sv
pc_queue.sv
inst_decoder.sv
inst_buffer.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- Makefile
TOP = tb_fetch_frontend

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
